// ==== include/i2c_master_consts.svh ====
// Bus timing, timeout and width constants of the I2C master, included wherever they are needed
`ifndef I2C_MASTER_CONSTS_SVH
`define I2C_MASTER_CONSTS_SVH

// Hold time of SDAT low with SCLK high that forms the start condition
`define I2C_START_DURATION 8'h25

// Low phase before data changes, also the minimum the synchronizers need
`define I2C_DATA_SETUP_DELAY 8'h05

// Data valid time before SCLK is released
`define I2C_DATA_HOLD_DELAY 8'h42

// Length of the SCLK high phase
`define I2C_SCLK_HIGH_DURATION 8'h20

// Bus free time after a stop condition
`define I2C_STOP_DURATION 8'h70

// Cycles after which a clock held low counts as a fault
`define I2C_TIMEOUT 8'hBF

`define I2C_DELAY_WIDTH 8
`define I2C_BYTE_WIDTH 8
`define I2C_BIT_IDX_WIDTH 3
`define I2C_ACK_COUNT_WIDTH 32

`endif

// ==== rtl/i2c_master_pkg.sv ====
// Shared types of the I2C master; modules import it with a wildcard import in their header
`include "i2c_master_consts.svh"

package i2c_master_pkg;

    // Bus phases of the bit sequencer
    typedef enum {
        PH_IDLE,
        PH_START,
        PH_WR_SETUP,
        PH_WR_SET,
        PH_WR_HOLD,
        PH_ACK_SETUP,
        PH_ACK_SET,
        PH_ACK_HOLD,
        PH_RD_SET,
        PH_RD_HOLD,
        PH_MACK_SETUP,
        PH_MACK_SET,
        PH_MACK_HOLD,
        PH_STOP_SETUP,
        PH_STOP_SET,
        PH_STOP_DELAY,
        PH_STOP,
        PH_ERROR
    } i2c_phase_t;

    typedef logic [`I2C_DELAY_WIDTH-1:0] delay_t;

    typedef logic [`I2C_BYTE_WIDTH-1:0] byte_t;

    typedef logic [`I2C_ACK_COUNT_WIDTH-1:0] ack_count_t;

endpackage

// ==== rtl/i2c_line_sync.sv ====
// Two-stage synchronizers for SCLK and SDAT, masked by the master's own drive, used by the top level
module i2c_line_sync (
    input  logic clock_i,
    input  logic reset_n_i,
    input  logic sclk_line_i,
    input  logic sdat_line_i,
    input  logic sclk_drive_i,
    input  logic sdat_drive_i,
    input  logic resync_i,
    output logic sclk_sync_o,
    output logic sdat_sync_o
);

    logic [1:0] sclk_chain;
    logic [1:0] sdat_chain;

    // A line we pull low ourselves reads as low in every stage
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            sclk_chain <= '0;
        end else if (resync_i) begin
            // A new phase has to see a fresh high on SCLK
            sclk_chain <= '0;
        end else begin
            sclk_chain[0] <= sclk_line_i & sclk_drive_i;
            sclk_chain[1] <= sclk_chain[0] & sclk_drive_i;
        end
    end

    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            sdat_chain <= '0;
        end else begin
            sdat_chain[0] <= sdat_line_i & sdat_drive_i;
            sdat_chain[1] <= sdat_chain[0] & sdat_drive_i;
        end
    end

    assign sclk_sync_o = sclk_chain[1];
    assign sdat_sync_o = sdat_chain[1];

endmodule

// ==== rtl/i2c_phase_timer.sv ====
// Phase timer and SCLK watchdog of the I2C master, both restarted by the sequencer on a phase change
`include "i2c_master_consts.svh"

module i2c_phase_timer
    import i2c_master_pkg::*;
(
    input  logic   clock_i,
    input  logic   reset_n_i,
    input  logic   start_i,
    input  delay_t delay_i,
    output logic   expired_o,
    output logic   timeout_o
);

    delay_t phase_cnt;
    logic   phase_run;
    delay_t wd_cnt;
    logic   wd_armed;

    // Phase counter runs down once and then stops, so expired_o is one cycle wide
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            phase_cnt <= '0;
            phase_run <= 1'b0;
        end else if (start_i) begin
            phase_cnt <= delay_i;
            phase_run <= 1'b1;
        end else if (phase_run) begin
            if (phase_cnt == '0) begin
                phase_run <= 1'b0;
            end else begin
                phase_cnt <= phase_cnt - 1'b1;
            end
        end
    end

    // Watchdog saturates at zero and keeps timeout_o high until the next start
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            wd_cnt   <= '0;
            wd_armed <= 1'b0;
        end else if (start_i) begin
            wd_cnt   <= delay_t'(`I2C_TIMEOUT);
            wd_armed <= 1'b1;
        end else if (wd_cnt != '0) begin
            wd_cnt <= wd_cnt - 1'b1;
        end
    end

    assign expired_o = phase_run & (phase_cnt == '0);
    assign timeout_o = wd_armed & (wd_cnt == '0);

endmodule

// ==== rtl/i2c_bit_sequencer.sv ====
// Bus phase FSM of the I2C master that drives SCLK and SDAT and exchanges bytes with the host
`include "i2c_master_consts.svh"

module i2c_bit_sequencer
    import i2c_master_pkg::*;
(
    input  logic       clock_i,
    input  logic       reset_n_i,
    input  logic       cmd_strobe_i,
    input  logic       ack_error_i,
    input  logic       data_available_i,
    input  byte_t      ctrl_wr_i,
    input  byte_t      data_i,
    input  byte_t      len_rd_i,
    input  logic       sclk_sync_i,
    input  logic       sdat_sync_i,
    input  logic       phase_expired_i,
    input  logic       timeout_i,
    output logic       sclk_o,
    output logic       sdat_o,
    output logic       phase_start_o,
    output delay_t     phase_delay_o,
    output logic       busy_o,
    output logic       error_o,
    output logic       data_valid_o,
    output logic       data_read_o,
    output logic       collision_detected_o,
    output logic       sclk_timeout_o,
    output byte_t      data_o,
    output ack_count_t acks_received_o
);

    i2c_phase_t phase_q, phase_d;
    i2c_phase_t after_stop_q, after_stop_d;
    logic [`I2C_BIT_IDX_WIDTH-1:0] idx_q, idx_d;
    byte_t      len_q, len_d;
    byte_t      buf_q, buf_d;
    ack_count_t ack_q, ack_d;
    logic       coll_q, coll_d;
    logic       tout_q, tout_d;
    logic       read_q, read_d;
    logic       fetch_q;
    logic       sclk_rel_q;
    logic       last_sdat_q;
    logic       sclk_release;
    logic       fault;

    function automatic delay_t phase_delay(input i2c_phase_t ph);
        case (ph)
            PH_START:      return delay_t'(`I2C_START_DURATION);
            PH_WR_SETUP,
            PH_ACK_SETUP,
            PH_MACK_SETUP,
            PH_STOP_SETUP: return delay_t'(`I2C_DATA_SETUP_DELAY);
            PH_WR_SET,
            PH_ACK_SET,
            PH_MACK_SET,
            PH_STOP_SET:   return delay_t'(`I2C_DATA_HOLD_DELAY);
            PH_RD_SET:     return delay_t'(`I2C_DATA_SETUP_DELAY + `I2C_DATA_HOLD_DELAY);
            PH_WR_HOLD,
            PH_ACK_HOLD,
            PH_RD_HOLD,
            PH_MACK_HOLD,
            PH_STOP_DELAY: return delay_t'(`I2C_SCLK_HIGH_DURATION);
            PH_STOP:       return delay_t'(`I2C_STOP_DURATION);
            default:       return delay_t'(0);
        endcase
    endfunction

    // SCLK is let go once the hold time of a set phase has run out
    assign sclk_release = phase_expired_i | sclk_rel_q;

    always_comb begin
        phase_d      = phase_q;
        after_stop_d = after_stop_q;
        idx_d        = idx_q;
        len_d        = len_q;
        buf_d        = buf_q;
        ack_d        = ack_q;
        coll_d       = coll_q;
        tout_d       = tout_q;
        read_d       = 1'b0;
        fault        = 1'b0;
        data_valid_o = 1'b0;
        error_o      = 1'b0;
        sclk_o       = 1'b1;
        sdat_o       = 1'b1;

        case (phase_q)
            PH_IDLE: begin
                after_stop_d = PH_IDLE;
                coll_d       = 1'b0;
                tout_d       = 1'b0;
                if (cmd_strobe_i) begin
                    buf_d   = ctrl_wr_i;
                    len_d   = len_rd_i;
                    ack_d   = '0;
                    phase_d = PH_START;
                end
            end
            PH_START: begin
                sdat_o = 1'b0;
                if (phase_expired_i) begin
                    // All ones points at the MSB, which goes out first
                    idx_d   = '1;
                    phase_d = PH_WR_SETUP;
                    if (!sclk_sync_i) begin
                        coll_d = 1'b1;
                        fault  = 1'b1;
                    end
                end
            end
            PH_WR_SETUP: begin
                // No check here, the slave may still hold SDAT from its acknowledge
                sclk_o = 1'b0;
                sdat_o = last_sdat_q;
                if (phase_expired_i) begin
                    phase_d = PH_WR_SET;
                end
            end
            PH_WR_SET: begin
                sclk_o = sclk_release;
                sdat_o = buf_q[idx_q];
                if (timeout_i) begin
                    tout_d = 1'b1;
                    fault  = 1'b1;
                end else if (sclk_sync_i) begin
                    phase_d = PH_WR_HOLD;
                end
            end
            PH_WR_HOLD: begin
                sdat_o = last_sdat_q;
                if (phase_expired_i) begin
                    if (idx_q != '0) begin
                        idx_d   = idx_q - 1'b1;
                        phase_d = PH_WR_SETUP;
                    end else begin
                        phase_d = PH_ACK_SETUP;
                    end
                    if (!sclk_sync_i || (sdat_sync_i != last_sdat_q)) begin
                        coll_d = 1'b1;
                        fault  = 1'b1;
                    end
                end
            end
            PH_ACK_SETUP: begin
                sclk_o = 1'b0;
                sdat_o = last_sdat_q;
                if (phase_expired_i) begin
                    phase_d = PH_ACK_SET;
                    if (sdat_sync_i != last_sdat_q) begin
                        coll_d = 1'b1;
                        fault  = 1'b1;
                    end
                end
            end
            PH_ACK_SET: begin
                sclk_o = sclk_release;
                if (timeout_i) begin
                    tout_d = 1'b1;
                    fault  = 1'b1;
                end else if (sclk_sync_i) begin
                    phase_d = PH_ACK_HOLD;
                end
            end
            PH_ACK_HOLD: begin
                if (fetch_q) begin
                    buf_d   = data_i;
                    idx_d   = '1;
                    phase_d = PH_WR_SETUP;
                end else if (phase_expired_i) begin
                    // SDAT still high here means the slave did not acknowledge
                    if (sdat_sync_i) begin
                        fault = 1'b1;
                    end else begin
                        ack_d = ack_q + 1'b1;
                        if (data_available_i) begin
                            read_d = 1'b1;
                        end else if (len_q != '0) begin
                            len_d   = len_q - 1'b1;
                            idx_d   = '1;
                            phase_d = PH_RD_SET;
                        end else begin
                            phase_d = PH_STOP_SETUP;
                        end
                    end
                    if (!sclk_sync_i) begin
                        coll_d = 1'b1;
                        fault  = 1'b1;
                    end
                end
            end
            PH_RD_SET: begin
                sclk_o = sclk_release;
                if (timeout_i) begin
                    tout_d = 1'b1;
                    fault  = 1'b1;
                end else if (sclk_sync_i) begin
                    phase_d = PH_RD_HOLD;
                end
            end
            PH_RD_HOLD: begin
                if (phase_expired_i) begin
                    buf_d[idx_q] = sdat_sync_i;
                    if (idx_q == '0) begin
                        phase_d = PH_MACK_SETUP;
                    end else begin
                        idx_d   = idx_q - 1'b1;
                        phase_d = PH_RD_SET;
                    end
                    if (!sclk_sync_i) begin
                        coll_d = 1'b1;
                        fault  = 1'b1;
                    end
                end
            end
            PH_MACK_SETUP: begin
                sclk_o = 1'b0;
                if (phase_expired_i) begin
                    phase_d = PH_MACK_SET;
                end
            end
            PH_MACK_SET: begin
                sclk_o = sclk_release;
                sdat_o = 1'b0;
                if (timeout_i) begin
                    tout_d = 1'b1;
                    fault  = 1'b1;
                end else if (sclk_sync_i) begin
                    phase_d = PH_MACK_HOLD;
                end
            end
            PH_MACK_HOLD: begin
                sdat_o = 1'b0;
                if (phase_expired_i) begin
                    data_valid_o = 1'b1;
                    if (len_q != '0) begin
                        len_d   = len_q - 1'b1;
                        idx_d   = '1;
                        phase_d = PH_RD_SET;
                    end else begin
                        // SDAT is already low with SCLK high, so the stop can follow directly
                        phase_d = PH_STOP_DELAY;
                    end
                end
            end
            PH_STOP_SETUP: begin
                sclk_o = 1'b0;
                sdat_o = last_sdat_q;
                if (phase_expired_i) begin
                    phase_d = PH_STOP_SET;
                end
            end
            PH_STOP_SET: begin
                sclk_o = sclk_release;
                sdat_o = 1'b0;
                // A stuck clock must not block the stop itself
                if (timeout_i) begin
                    tout_d       = 1'b1;
                    after_stop_d = PH_ERROR;
                    phase_d      = PH_STOP_DELAY;
                end else if (sclk_sync_i) begin
                    phase_d = PH_STOP_DELAY;
                end
            end
            PH_STOP_DELAY: begin
                sdat_o = 1'b0;
                if (phase_expired_i) begin
                    phase_d = PH_STOP;
                end
            end
            PH_STOP: begin
                // Bus free time, the lines are released as in idle
                if (phase_expired_i) begin
                    phase_d = after_stop_q;
                end
            end
            PH_ERROR: begin
                error_o = 1'b1;
                if (ack_error_i) begin
                    phase_d = PH_IDLE;
                end
            end
            default: begin
                phase_d = PH_IDLE;
            end
        endcase

        // Every fault ends the transfer with a stop and then waits in the error state
        if (fault) begin
            after_stop_d = PH_ERROR;
            phase_d      = PH_STOP_SETUP;
            read_d       = 1'b0;
        end
    end

    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            phase_q      <= PH_IDLE;
            after_stop_q <= PH_IDLE;
            idx_q        <= '0;
            len_q        <= '0;
            ack_q        <= '0;
            coll_q       <= 1'b0;
            tout_q       <= 1'b0;
            read_q       <= 1'b0;
            fetch_q      <= 1'b0;
            sclk_rel_q   <= 1'b0;
            last_sdat_q  <= 1'b1;
        end else begin
            phase_q      <= phase_d;
            after_stop_q <= after_stop_d;
            idx_q        <= idx_d;
            len_q        <= len_d;
            ack_q        <= ack_d;
            coll_q       <= coll_d;
            tout_q       <= tout_d;
            read_q       <= read_d;
            fetch_q      <= read_q;
            sclk_rel_q   <= phase_start_o ? 1'b0 : sclk_release;
            last_sdat_q  <= sdat_o;
        end
    end

    always_ff @(posedge clock_i) begin
        buf_q <= buf_d;
    end

    assign phase_start_o        = (phase_d != phase_q);
    assign phase_delay_o        = phase_delay(phase_d);
    assign busy_o               = (phase_q != PH_IDLE) && (phase_q != PH_ERROR);
    assign data_read_o          = read_q;
    assign data_o               = buf_q;
    assign collision_detected_o = coll_q;
    assign sclk_timeout_o       = tout_q;
    assign acks_received_o      = ack_q;

endmodule

// ==== rtl/i2c_master.sv ====
// Top level of the single-master I2C bus master; instantiate it and connect the open-drain pins
module i2c_master
    import i2c_master_pkg::*;
(
    input  logic       clock_i,
    input  logic       reset_n_i,
    input  logic       cmd_strobe_i,
    input  byte_t      len_rd_i,
    output logic       data_valid_o,
    output byte_t      data_o,
    input  byte_t      ctrl_wr_i,
    input  logic       data_available_i,
    output logic       data_read_o,
    input  byte_t      data_i,
    output logic       i2c_sclk_o,
    output logic       i2c_sdat_o,
    input  logic       i2c_sclk_i,
    input  logic       i2c_sdat_i,
    output logic       busy_o,
    output logic       error_o,
    output logic       collision_detected_o,
    output logic       sclk_timeout_o,
    output logic       sclk_sync_o,
    output logic       sdat_sync_o,
    input  logic       ack_error_i,
    output ack_count_t acks_received_o
);

    logic   phase_start;
    delay_t phase_delay;
    logic   phase_expired;
    logic   timeout;

    i2c_line_sync line_sync_inst (
        .clock_i      (clock_i),
        .reset_n_i    (reset_n_i),
        .sclk_line_i  (i2c_sclk_i),
        .sdat_line_i  (i2c_sdat_i),
        .sclk_drive_i (i2c_sclk_o),
        .sdat_drive_i (i2c_sdat_o),
        .resync_i     (phase_start),
        .sclk_sync_o  (sclk_sync_o),
        .sdat_sync_o  (sdat_sync_o)
    );

    i2c_phase_timer phase_timer_inst (
        .clock_i   (clock_i),
        .reset_n_i (reset_n_i),
        .start_i   (phase_start),
        .delay_i   (phase_delay),
        .expired_o (phase_expired),
        .timeout_o (timeout)
    );

    i2c_bit_sequencer bit_sequencer_inst (
        .clock_i              (clock_i),
        .reset_n_i            (reset_n_i),
        .cmd_strobe_i         (cmd_strobe_i),
        .ack_error_i          (ack_error_i),
        .data_available_i     (data_available_i),
        .ctrl_wr_i            (ctrl_wr_i),
        .data_i               (data_i),
        .len_rd_i             (len_rd_i),
        .sclk_sync_i          (sclk_sync_o),
        .sdat_sync_i          (sdat_sync_o),
        .phase_expired_i      (phase_expired),
        .timeout_i            (timeout),
        .sclk_o               (i2c_sclk_o),
        .sdat_o               (i2c_sdat_o),
        .phase_start_o        (phase_start),
        .phase_delay_o        (phase_delay),
        .busy_o               (busy_o),
        .error_o              (error_o),
        .data_valid_o         (data_valid_o),
        .data_read_o          (data_read_o),
        .collision_detected_o (collision_detected_o),
        .sclk_timeout_o       (sclk_timeout_o),
        .data_o               (data_o),
        .acks_received_o      (acks_received_o)
    );

endmodule

// ==== tests/i2c_slave_model.sv ====
// Open-drain I2C slave model for the testbench; acknowledges, returns read data and can force faults
module i2c_slave_model (
    input  logic       clock_i,
    input  logic       reset_n_i,
    input  logic       sclk_i,
    input  logic       sdat_i,
    input  logic       ack_en_i,
    input  logic [3:0] wr_frames_i,
    input  logic [7:0] rd_byte0_i,
    input  logic [7:0] rd_byte1_i,
    input  logic       coll_en_i,
    input  logic       hold_sclk_i,
    output logic       sclk_o,
    output logic       sdat_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] rx_bytes [0:3];
    int         rx_count;
    int         stop_count;
    logic       active;
    int         bit_pos;
    int         frame;
    int         pend;
    logic [7:0] shreg;
    logic       nxt_sdat;
    logic       prev_sclk;
    logic       prev_sdat;

    function automatic logic drive_for(input int fr, input int pos);
        logic [7:0] rd;
        if (fr < wr_frames_i) begin
            if (pos == 8) begin
                return !ack_en_i;
            end
            // Pull SDAT low during the second control bit to collide with the master
            return !(coll_en_i && fr == 0 && pos == 1);
        end
        rd = (fr == wr_frames_i) ? rd_byte0_i : (fr == wr_frames_i + 1) ? rd_byte1_i : 8'hFF;
        return (pos < 8) ? rd[7 - pos] : 1'b1;
    endfunction

    // Lines are sampled mid-cycle, so simultaneous edges of the master never look like a stop
    always @(negedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            active     = 1'b0;
            rx_count   = 0;
            stop_count = 0;
            bit_pos    = 0;
            frame      = 0;
            pend       = 0;
            shreg      = '0;
            nxt_sdat   = 1'b1;
            sdat_o     = 1'b1;
            prev_sclk  = 1'b1;
            prev_sdat  = 1'b1;
        end else begin
            if (sclk_i && prev_sclk && prev_sdat && !sdat_i) begin
                active   = 1'b1;
                bit_pos  = 0;
                frame    = 0;
                rx_count = 0;
                pend     = 0;
                sdat_o   = 1'b1;
            end else if (sclk_i && prev_sclk && !prev_sdat && sdat_i) begin
                active     = 1'b0;
                stop_count = stop_count + 1;
                pend       = 0;
                sdat_o     = 1'b1;
            end else if (active) begin
                if (sclk_i && !prev_sclk) begin
                    if (bit_pos < 8) begin
                        shreg   = {shreg[6:0], sdat_i};
                        bit_pos = bit_pos + 1;
                    end else begin
                        if (frame < wr_frames_i && rx_count < 4) begin
                            rx_bytes[rx_count] = shreg;
                            rx_count = rx_count + 1;
                        end
                        bit_pos = 0;
                        frame   = frame + 1;
                    end
                end
                // SDAT changes well into the low phase, after the master's setup check
                if (!sclk_i && prev_sclk) begin
                    nxt_sdat = drive_for(frame, bit_pos);
                    pend     = 10;
                end else if (pend > 0) begin
                    pend = pend - 1;
                    if (pend == 0) begin
                        sdat_o = nxt_sdat;
                    end
                end
            end
            prev_sclk = sclk_i;
            prev_sdat = sdat_i;
        end
    end

    assign sclk_o = !hold_sclk_i;

endmodule

// ==== tests/tb_i2c_master.sv ====
// Testbench of the I2C master; runs write, read and fault transfers against the slave model
`include "i2c_master_consts.svh"

module tb_i2c_master
    import i2c_master_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CYCLES  = `I2C_DATA_SETUP_DELAY + `I2C_DATA_HOLD_DELAY
                                 + `I2C_SCLK_HIGH_DURATION + 10;
    localparam int BYTE_CYCLES = 9 * BIT_CYCLES;
    localparam int STOP_CYCLES = `I2C_DATA_SETUP_DELAY + `I2C_DATA_HOLD_DELAY
                                 + `I2C_SCLK_HIGH_DURATION + `I2C_STOP_DURATION + 10;
    // Nine bytes and five stops over all tests, plus two watchdog periods, with a margin of 4
    localparam int RUN_CYCLES  = 4 * (9 * BYTE_CYCLES + 5 * STOP_CYCLES + 2 * `I2C_TIMEOUT + 200);
    localparam int WAIT_LIMIT  = 4 * BYTE_CYCLES + 2 * STOP_CYCLES + 4 * `I2C_TIMEOUT;

    logic clock_i, reset_n;
    logic cmd_strobe, ack_error, data_available;
    byte_t len_rd, ctrl_wr, data_in, data_out;
    logic data_valid, data_read, busy, error, collision, sclk_timeout, sclk_sync, sdat_sync;
    logic m_sclk, m_sdat, s_sclk, s_sdat, sclk_bus, sdat_bus;
    ack_count_t acks;
    logic ack_en, coll_en, hold_sclk;
    logic [3:0] wr_frames;
    byte_t rd0, rd1;
    byte_t host_q[$];
    byte_t rd_seen[$];
    int read_pulses, feed_cnt, fail_count, test_count, test_fails;

    assign sclk_bus = m_sclk & s_sclk;
    assign sdat_bus = m_sdat & s_sdat;

    i2c_master i2c_master_inst (
        .clock_i(clock_i), .reset_n_i(reset_n), .cmd_strobe_i(cmd_strobe), .len_rd_i(len_rd),
        .data_valid_o(data_valid), .data_o(data_out), .ctrl_wr_i(ctrl_wr),
        .data_available_i(data_available), .data_read_o(data_read), .data_i(data_in),
        .i2c_sclk_o(m_sclk), .i2c_sdat_o(m_sdat), .i2c_sclk_i(sclk_bus), .i2c_sdat_i(sdat_bus),
        .busy_o(busy), .error_o(error), .collision_detected_o(collision),
        .sclk_timeout_o(sclk_timeout), .sclk_sync_o(sclk_sync), .sdat_sync_o(sdat_sync),
        .ack_error_i(ack_error), .acks_received_o(acks)
    );

    i2c_slave_model slave_inst (
        .clock_i(clock_i), .reset_n_i(reset_n), .sclk_i(sclk_bus), .sdat_i(sdat_bus),
        .ack_en_i(ack_en), .wr_frames_i(wr_frames), .rd_byte0_i(rd0), .rd_byte1_i(rd1),
        .coll_en_i(coll_en), .hold_sclk_i(hold_sclk), .sclk_o(s_sclk), .sdat_o(s_sdat)
    );

    always #20 clock_i = ~clock_i;

    // Host strobes from the master last a single cycle
    assert property (@(posedge clock_i) disable iff (!reset_n) data_read |=> !data_read)
        else begin
            $display("data_read_o stayed high for more than one cycle");
            fail_count++;
        end
    assert property (@(posedge clock_i) disable iff (!reset_n) data_valid |=> !data_valid)
        else begin
            $display("data_valid_o stayed high for more than one cycle");
            fail_count++;
        end

    // Both synchronizers lag the bus by two cycles and read low wherever the master pulls low
    assert property (@(posedge clock_i) disable iff (!reset_n)
        $past(reset_n, 2) |->
            sdat_sync == ($past(sdat_bus, 2) & $past(m_sdat, 2) & $past(m_sdat)))
        else begin
            $display("sdat_sync_o does not follow the SDAT line from two cycles before");
            fail_count++;
        end
    assert property (@(posedge clock_i) disable iff (!reset_n)
        sclk_sync |-> ($past(sclk_bus, 2) && $past(m_sclk, 2) && $past(m_sclk)))
        else begin
            $display("sclk_sync_o went high without SCLK high two cycles before");
            fail_count++;
        end

    // Host side counts pulses, collects read bytes and advances data_i after it is taken
    always @(negedge clock_i) begin
        if (feed_cnt > 0) begin
            feed_cnt--;
            if (feed_cnt == 0) begin
                void'(host_q.pop_front());
                if (host_q.size() > 0) begin
                    data_in = host_q[0];
                end else begin
                    data_available = 1'b0;
                end
            end
        end
        if (data_read) begin
            read_pulses++;
            feed_cnt = 2;
        end
        if (data_valid) begin
            rd_seen.push_back(data_out);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Failure: %s", what);
            fail_count++;
        end
    endtask

    task automatic start_transfer(input byte_t ctrl, input byte_t len);
        ctrl_wr = ctrl;
        len_rd = len;
        cmd_strobe = 1'b1;
        @(negedge clock_i);
        cmd_strobe = 1'b0;
        @(negedge clock_i);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(negedge clock_i);
            n++;
        end
        check_true(!busy, "busy_o did not fall before the wait limit");
    endtask

    task automatic wait_error();
        int n;
        n = 0;
        while (!error && n < WAIT_LIMIT) begin
            @(negedge clock_i);
            n++;
        end
        check_true(error, "error_o did not rise before the wait limit");
    endtask

    task automatic clear_error();
        ack_error = 1'b1;
        @(negedge clock_i);
        ack_error = 1'b0;
        @(negedge clock_i);
        check_value("busy_o", busy, 0);
        check_value("error_o", error, 0);
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %s", test_count, name,
                 (fail_count == test_fails) ? "ok" : "errors");
        test_fails = fail_count;
        repeat (20) @(negedge clock_i);
    endtask

    initial begin
        #(RUN_CYCLES * 40);
        $display("Run stopped by the watchdog after %0d cycles", RUN_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        byte_t b1, b2;
        int stops_before;
        void'($urandom(70));
        clock_i = 1'b0;
        reset_n = 1'b0;
        cmd_strobe = 1'b0;
        ack_error = 1'b0;
        data_available = 1'b0;
        len_rd = '0;
        ctrl_wr = '0;
        data_in = '0;
        ack_en = 1'b1;
        coll_en = 1'b0;
        hold_sclk = 1'b0;
        wr_frames = 4'd8;
        rd0 = '0;
        rd1 = '0;
        read_pulses = 0;
        feed_cnt = 0;
        fail_count = 0;
        test_count = 0;
        test_fails = 0;
        repeat (4) @(negedge clock_i);
        reset_n = 1'b1;
        @(negedge clock_i);

        check_value("busy_o", busy, 0);
        check_value("error_o", error, 0);
        check_value("i2c_sclk_o", m_sclk, 1);
        check_value("i2c_sdat_o", m_sdat, 1);
        check_value("acks_received_o", acks, 0);
        end_test("reset values");

        b1 = byte_t'($urandom);
        b2 = byte_t'($urandom);
        host_q = '{b1, b2};
        data_in = b1;
        data_available = 1'b1;
        start_transfer(8'hA4, 8'd0);
        wait_idle();
        check_value("slave byte count", slave_inst.rx_count, 3);
        check_value("slave byte 0", slave_inst.rx_bytes[0], 8'hA4);
        check_value("slave byte 1", slave_inst.rx_bytes[1], b1);
        check_value("slave byte 2", slave_inst.rx_bytes[2], b2);
        check_value("data_read_o pulses", read_pulses, 2);
        check_value("acks_received_o", acks, 3);
        check_value("error_o", error, 0);
        end_test("write two bytes");

        rd0 = byte_t'($urandom);
        rd1 = byte_t'($urandom);
        wr_frames = 4'd1;
        rd_seen.delete();
        start_transfer(8'hA5, 8'd2);
        wait_idle();
        check_value("data_valid_o pulses", rd_seen.size(), 2);
        if (rd_seen.size() == 2) begin
            check_value("data_o byte 0", rd_seen[0], rd0);
            check_value("data_o byte 1", rd_seen[1], rd1);
        end
        check_value("acks_received_o", acks, 1);
        end_test("read two bytes");

        wr_frames = 4'd8;
        ack_en = 1'b0;
        stops_before = slave_inst.stop_count;
        start_transfer(8'hA4, 8'd0);
        wait_error();
        check_true(slave_inst.stop_count == stops_before + 1, "no stop before the NACK error");
        ack_en = 1'b1;
        clear_error();
        end_test("missing acknowledge");

        coll_en = 1'b1;
        start_transfer(8'hC2, 8'd0);
        wait_error();
        check_value("collision_detected_o", collision, 1);
        coll_en = 1'b0;
        clear_error();
        end_test("collision");

        start_transfer(8'hA4, 8'd0);
        while (sclk_bus) begin
            @(negedge clock_i);
        end
        hold_sclk = 1'b1;
        wait_error();
        check_value("sclk_timeout_o", sclk_timeout, 1);
        hold_sclk = 1'b0;
        clear_error();
        end_test("clock held low");

        $display("tests: %0d, failed checks: %0d", test_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== i2c_master.f ====
+incdir+include
rtl/i2c_master_pkg.sv
rtl/i2c_line_sync.sv
rtl/i2c_phase_timer.sv
rtl/i2c_bit_sequencer.sv
rtl/i2c_master.sv
tests/i2c_slave_model.sv
tests/tb_i2c_master.sv

// ==== Bender.yml ====
package:
  name: i2c_master

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/i2c_master_pkg.sv
      - rtl/i2c_line_sync.sv
      - rtl/i2c_phase_timer.sv
      - rtl/i2c_bit_sequencer.sv
      - rtl/i2c_master.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/i2c_slave_model.sv
      - tests/tb_i2c_master.sv
